/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the run by its log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f segment_marquee.f --top-module tb_segment_marquee \
    --Mdir obj_dir -o tb_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "Checks failed" sim.log && exit 1
grep -q "All checks passed" sim.log || exit 1
exit 0

/* segment_marquee.f */
+incdir+testbench
verilog/marquee_pkg.sv
verilog/digit_scanner.sv
verilog/frame_timer.sv
verilog/effect_sequencer.sv
verilog/frame_composer.sv
verilog/segment_marquee.sv
testbench/tb_segment_marquee.sv

/* testbench/marquee_model.svh */
`ifndef marquee_model_svh
`define marquee_model_svh

// Expected glyph for digit d, with the animation flattened to frames 0 to 33.
// Char n sits in chars[7*n +: 7]
function automatic glyph_t expected_glyph(input int frame, input int d, input logic [48:0] chars);
    int pos;
    glyph_t g;
    g = seg_null;
    if (frame == 0 || frame == 33) begin
        g = seg_floor;
    end else if (frame <= 7) begin
        // Ball falls from digit 6 toward digit 0
        pos = 7 - frame;
        g = (d < pos) ? seg_floor : (d == pos) ? seg_ball : seg_null;
    end else if (frame == 8) begin
        g = (d == 0) ? chars[6:0] : seg_null;
    end else if (frame <= 14) begin
        pos = frame - 8;
        g = (d == 0) ? chars[6:0] : (d < pos) ? seg_dash : (d == pos) ? seg_carrier : seg_null;
    end else if (frame == 15) begin
        g = (d == 0) ? chars[6:0] : seg_dash;
    end else if (frame <= 21) begin
        // Carrier heads back left with the chars trailing behind it
        pos = 22 - frame;
        g = (d == 0) ? chars[6:0] : (d < pos) ? seg_dash :
            (d == pos) ? seg_carrier : chars[7*(d-pos) +: 7];
    end else if (frame == 23) begin
        g = seg_null;
    end else if (frame <= 25) begin
        g = chars[7*d +: 7];
    end else begin
        pos = 32 - frame;
        g = (d < pos) ? chars[7*d +: 7] : (d == pos) ? seg_dash : seg_floor;
    end
    return g;
endfunction

// Right-shifting Galois LFSR, taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
endfunction

// Digit d pulls bit 6 - d low, -1 if no bit is low
function automatic int select_to_digit(input logic [6:0] sel);
    int digit;
    digit = -1;
    for (int d = 0; d < 7; d++) begin
        if (sel[6-d] == 1'b0) begin
            digit = d;
        end
    end
    return digit;
endfunction

function automatic int low_bit_count(input logic [6:0] sel);
    int n;
    n = 0;
    for (int i = 0; i < 7; i++) begin
        if (sel[i] == 1'b0) begin
            n++;
        end
    end
    return n;
endfunction

`endif

/* testbench/tb_segment_marquee.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_segment_marquee import marquee_pkg::*;;

    localparam int scan_cycles = 4;
    localparam int slowest_frame_cycles = 64;
    localparam int reset_cycles = 3;
    localparam int drive_delay = 2;
    localparam int mode_off = 0;
    localparam int mode_floor = 1;
    localparam int mode_anim = 2;
    localparam int test_cycles = 68 * (slowest_frame_cycles >> 3) + 12 * slowest_frame_cycles
        + 12 * (slowest_frame_cycles >> 1) + 12 * (slowest_frame_cycles >> 2)
        + 4 * (slowest_frame_cycles >> 3);
    localparam int watchdog_cycles = 2 * test_cycles + reset_cycles;

    logic        clk;
    logic        reset;
    logic        run;
    rate_t       rate;
    logic [48:0] chars;
    logic [6:0]  select;
    glyph_t      segments;

    logic [31:0] lfsr_state;
    int          cycle_count = 0;
    int          mode;
    int          mode_start;
    int          frame_len;
    bit          scan_seen = 1'b0;
    int          prev_digit;
    int          hold;

    `include "marquee_model.svh"

    segment_marquee #(
        .scan_cycles(scan_cycles),
        .slowest_frame_cycles(slowest_frame_cycles)
    ) u_segment_marquee (
        .clk(clk),
        .reset(reset),
        .run(run),
        .rate(rate),
        .char0(chars[6:0]),
        .char1(chars[13:7]),
        .char2(chars[20:14]),
        .char3(chars[27:21]),
        .char4(chars[34:28]),
        .char5(chars[41:35]),
        .char6(chars[48:42]),
        .select(select),
        .segments(segments)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    task check_value(input string name, input logic [31:0] got, input logic [31:0] expected);
        if (got !== expected) begin
            $display("mismatch %s: got %h, expected %h", name, got, expected);
            $display("Checks failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    task check_idle_outputs();
        check_value("select", 32'(select), 32'h7f);
        check_value("segments", 32'(segments), 32'(seg_null));
    endtask

    // Each char takes seven LFSR bits
    task load_random_chars();
        for (int i = 0; i < 49; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            chars[i] = lfsr_state[0];
        end
    endtask

    task hold_run_low(input int cycles);
        @(posedge clk);
        #drive_delay;
        run = 1'b0;
        mode = mode_floor;
        mode_start = cycle_count;
        repeat (cycles) @(posedge clk);
    endtask

    task play_frames(input rate_t new_rate, input int frames);
        @(posedge clk);
        #drive_delay;
        rate = new_rate;
        frame_len = slowest_frame_cycles >> new_rate;
        run = 1'b1;
        mode = mode_anim;
        mode_start = cycle_count;
        repeat (frames * frame_len) @(posedge clk);
    endtask

    // ========================================
    // Output checks
    // ========================================

    // Segments against the reference, skipping the cycles right after a boundary
    always @(negedge clk) begin : compare_segments
        int k;
        int d;
        k = cycle_count - mode_start;
        d = select_to_digit(select);
        if (mode == mode_floor && k >= 3 && d >= 0) begin
            check_value("segments", 32'(segments), 32'(seg_floor));
        end else if (mode == mode_anim && (k % frame_len) >= 3 && d >= 0) begin
            check_value("segments", 32'(segments),
                        32'(expected_glyph((k / frame_len) % 34, d, chars)));
        end
    end

    // Scan order and dwell time of the digit select
    always @(negedge clk) begin : check_scan
        int d;
        d = select_to_digit(select);
        if (!reset && (scan_seen || select != 7'h7f)) begin
            check_value("select_low_bits", 32'(low_bit_count(select)), 32'd1);
            if (!scan_seen) begin
                check_value("select_digit", 32'(d), 32'd0);
                scan_seen = 1'b1;
                hold = 1;
            end else if (d == prev_digit) begin
                hold++;
                if (hold > scan_cycles) begin
                    check_value("select_hold", 32'(hold), 32'(scan_cycles));
                end
            end else begin
                check_value("select_hold", 32'(hold), 32'(scan_cycles));
                check_value("select_digit", 32'(d), 32'((prev_digit + 1) % num_digits));
                hold = 1;
            end
            prev_digit = d;
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: the test sequence did not finish in %0d cycles", watchdog_cycles);
        $display("Checks failed");
        $fatal(1, "watchdog expired");
    end

    // ========================================
    // Stimulus
    // ========================================

    initial begin
        reset = 1'b1;
        run = 1'b0;
        rate = 2'd0;
        chars = {7{seg_dash}};
        lfsr_state = 32'hbbc8;
        mode = mode_off;
        mode_start = 0;
        frame_len = slowest_frame_cycles;
        repeat (reset_cycles - 1) begin
            @(negedge clk);
            check_idle_outputs();
        end
        @(posedge clk);
        #drive_delay;
        reset = 1'b0;
        @(negedge clk);
        check_idle_outputs();

        // Run low keeps the floor whatever the chars and rate
        hold_run_low(20);
        for (int r = 0; r < 4; r++) begin
            @(posedge clk);
            #drive_delay;
            rate = rate_t'(r);
            load_random_chars();
            repeat (10) @(posedge clk);
        end

        // Two full passes at the fastest rate, including the wrap to frame 0
        play_frames(2'd3, 68);

        for (int r = 0; r < 3; r++) begin
            hold_run_low(20);
            #drive_delay;
            load_random_chars();
            play_frames(rate_t'(r), 12);
        end

        // Drop run in the middle of the fetch, then restart from frame 0
        hold_run_low(20);
        play_frames(2'd3, 4);

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/digit_scanner.sv */
`timescale 1ns/1ps
`default_nettype none

module digit_scanner import marquee_pkg::*; #(
    parameter int scan_cycles = default_scan_cycles
) (
    input  logic   clk,
    input  logic   reset,
    output digit_t digit
);

    localparam int count_w = $clog2(scan_cycles + 1);

    logic [count_w-1:0] count;
    logic               count_done;

    assign count_done = (count == count_w'(scan_cycles - 1));

    // Each digit is lit for scan_cycles clocks, then the scan moves right
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
            digit <= '0;
        end else if (count_done) begin
            count <= '0;
            if (digit == digit_t'(num_digits - 1)) begin
                digit <= '0;
            end else begin
                digit <= digit + 3'd1;
            end
        end else begin
            count <= count + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* verilog/effect_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module effect_sequencer import marquee_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   run,
    input  logic   frame_tick,
    output phase_t phase,
    output step_t  step
);

    step_t  last_step;
    phase_t next_phase;

    // Length of each phase minus one, and the phase that follows it
    always_comb begin
        last_step = 3'd0;
        next_phase = ph_floor;
        case (phase)
            ph_floor: begin
                next_phase = ph_drop;
            end
            ph_drop: begin
                last_step = 3'd6;
                next_phase = ph_land;
            end
            ph_land: begin
                next_phase = ph_fetch;
            end
            ph_fetch: begin
                last_step = 3'd5;
                next_phase = ph_turn;
            end
            ph_turn: begin
                next_phase = ph_deliver;
            end
            ph_deliver: begin
                last_step = 3'd5;
                next_phase = ph_show;
            end
            ph_show: begin
                next_phase = ph_blank;
            end
            ph_blank: begin
                next_phase = ph_hold;
            end
            ph_hold: begin
                last_step = 3'd1;
                next_phase = ph_wipe;
            end
            ph_wipe: begin
                last_step = 3'd6;
                next_phase = ph_clear;
            end
            default: begin
                next_phase = ph_floor;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || !run) begin
            phase <= ph_floor;
            step <= '0;
        end else if (frame_tick) begin
            if (step == last_step) begin
                phase <= next_phase;
                step <= '0;
            end else begin
                step <= step + 3'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/frame_composer.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_composer import marquee_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  digit_t     digit,
    input  phase_t     phase,
    input  step_t      step,
    input  glyph_t     char0,
    input  glyph_t     char1,
    input  glyph_t     char2,
    input  glyph_t     char3,
    input  glyph_t     char4,
    input  glyph_t     char5,
    input  glyph_t     char6,
    output logic [6:0] select,
    output glyph_t     segments
);

    glyph_t chars [num_digits];
    glyph_t next_glyph;
    digit_t rev_pos;
    digit_t fwd_pos;

    assign chars[0] = char0;
    assign chars[1] = char1;
    assign chars[2] = char2;
    assign chars[3] = char3;
    assign chars[4] = char4;
    assign chars[5] = char5;
    assign chars[6] = char6;

    // Leftward moves (ball, return trip, wipe) start at digit 6; the fetch starts at 1
    assign rev_pos = 3'd6 - step;
    assign fwd_pos = step + 3'd1;

    // ========================================
    // Glyph for the digit being scanned
    // ========================================

    always_comb begin
        next_glyph = seg_null;
        case (phase)
            ph_floor, ph_clear: begin
                next_glyph = seg_floor;
            end
            ph_drop: begin
                if (digit < rev_pos) begin
                    next_glyph = seg_floor;
                end else if (digit == rev_pos) begin
                    next_glyph = seg_ball;
                end
            end
            ph_land: begin
                if (digit == 3'd0) begin
                    next_glyph = char0;
                end
            end
            ph_fetch: begin
                if (digit == 3'd0) begin
                    next_glyph = char0;
                end else if (digit < fwd_pos) begin
                    next_glyph = seg_dash;
                end else if (digit == fwd_pos) begin
                    next_glyph = seg_carrier;
                end
            end
            ph_turn: begin
                next_glyph = (digit == 3'd0) ? char0 : seg_dash;
            end
            ph_deliver: begin
                // Chars trail the carrier in order as it heads back left
                if (digit == 3'd0) begin
                    next_glyph = char0;
                end else if (digit < rev_pos) begin
                    next_glyph = seg_dash;
                end else if (digit == rev_pos) begin
                    next_glyph = seg_carrier;
                end else begin
                    next_glyph = chars[digit - rev_pos];
                end
            end
            ph_show, ph_hold: begin
                next_glyph = chars[digit];
            end
            ph_wipe: begin
                if (digit < rev_pos) begin
                    next_glyph = chars[digit];
                end else if (digit == rev_pos) begin
                    next_glyph = seg_dash;
                end else begin
                    next_glyph = seg_floor;
                end
            end
            default: begin
                next_glyph = seg_null;
            end
        endcase
    end

    // Select and segments are registered together so they always describe the same digit
    always_ff @(posedge clk) begin
        if (reset) begin
            select <= 7'b1111111;
            segments <= seg_null;
        end else begin
            select <= ~(7'b1000000 >> digit);
            segments <= next_glyph;
        end
    end

endmodule

`default_nettype wire

/* verilog/frame_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_timer import marquee_pkg::*; #(
    parameter int slowest_frame_cycles = default_slowest_frame_cycles
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  run,
    input  rate_t rate,
    output logic  frame_tick
);

    localparam int count_w = $clog2(slowest_frame_cycles + 1);

    logic [count_w-1:0] count;
    logic [count_w-1:0] divisor;
    logic [count_w:0]   count_next;

    // Rates 0 to 3 halve the frame length each step
    assign divisor = count_w'(slowest_frame_cycles >> rate);
    assign count_next = {1'b0, count} + 1'b1;

    // The tick is registered, so it lands exactly divisor cycles after the count starts.
    // A rate change is compared against the count already in progress
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
            frame_tick <= 1'b0;
        end else if (!run) begin
            count <= '0;
            frame_tick <= 1'b0;
        end else if (count_next >= {1'b0, divisor}) begin
            count <= '0;
            frame_tick <= 1'b1;
        end else begin
            count <= count_next[count_w-1:0];
            frame_tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* verilog/marquee_pkg.sv */
`default_nettype none

package marquee_pkg;

    // ========================================
    // Display geometry and timing defaults
    // ========================================

    localparam int num_digits = 7;

    // Cycles each digit stays lit, and the frame length at the slowest rate
    localparam int default_scan_cycles = 25001;
    localparam int default_slowest_frame_cycles = 50000000;

    typedef logic [2:0] digit_t;
    typedef logic [2:0] step_t;
    typedef logic [1:0] rate_t;

    // ========================================
    // Glyphs, active low
    // ========================================

    typedef logic [6:0] glyph_t;

    localparam glyph_t seg_null = 7'b1111111;
    localparam glyph_t seg_floor = 7'b1111101;
    localparam glyph_t seg_ball = 7'b0111000;
    localparam glyph_t seg_dash = 7'b0111111;
    localparam glyph_t seg_carrier = 7'b1001100;

    // Animation phases in playing order, 34 frames in total
    typedef enum logic [3:0] {
        ph_floor   = 4'd0,
        ph_drop    = 4'd1,
        ph_land    = 4'd2,
        ph_fetch   = 4'd3,
        ph_turn    = 4'd4,
        ph_deliver = 4'd5,
        ph_show    = 4'd6,
        ph_blank   = 4'd7,
        ph_hold    = 4'd8,
        ph_wipe    = 4'd9,
        ph_clear   = 4'd10
    } phase_t;

endpackage

`default_nettype wire

/* verilog/segment_marquee.sv */
`timescale 1ns/1ps
`default_nettype none

module segment_marquee import marquee_pkg::*; #(
    parameter int scan_cycles = default_scan_cycles,
    parameter int slowest_frame_cycles = default_slowest_frame_cycles
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       run,
    input  rate_t      rate,
    input  glyph_t     char0,
    input  glyph_t     char1,
    input  glyph_t     char2,
    input  glyph_t     char3,
    input  glyph_t     char4,
    input  glyph_t     char5,
    input  glyph_t     char6,
    output logic [6:0] select,
    output glyph_t     segments
);

    digit_t digit;
    logic   frame_tick;
    phase_t phase;
    step_t  step;

    // The scan runs all the time, run only gates the animation
    digit_scanner #(
        .scan_cycles(scan_cycles)
    ) u_digit_scanner (
        .clk(clk),
        .reset(reset),
        .digit(digit)
    );

    frame_timer #(
        .slowest_frame_cycles(slowest_frame_cycles)
    ) u_frame_timer (
        .clk(clk),
        .reset(reset),
        .run(run),
        .rate(rate),
        .frame_tick(frame_tick)
    );

    effect_sequencer u_effect_sequencer (
        .clk(clk),
        .reset(reset),
        .run(run),
        .frame_tick(frame_tick),
        .phase(phase),
        .step(step)
    );

    frame_composer u_frame_composer (
        .clk(clk),
        .reset(reset),
        .digit(digit),
        .phase(phase),
        .step(step),
        .char0(char0),
        .char1(char1),
        .char2(char2),
        .char3(char3),
        .char4(char4),
        .char5(char5),
        .char6(char6),
        .select(select),
        .segments(segments)
    );

endmodule

`default_nettype wire
